// ==== hdl/mini_ss_pkg.sv ====
/*
 * mini subsystem package
 * sizes, memory map, instruction encoding and the request/response
 * bus structs shared by the core, the arbiter and the RAM
 */
package mini_ss_pkg;

    // word address and data sizes
    localparam int addr_width = 10;
    localparam int data_width = 32;

    // memory map in word addresses
    localparam logic [addr_width-1:0] boot_addr = '0;
    localparam logic [addr_width-1:0] exit_addr = '1;

    // the core treats any opcode outside this list as halt
    typedef enum logic [3:0] {
        OP_LOAD  = 4'h1,
        OP_ADD   = 4'h2,
        OP_XOR   = 4'h3,
        OP_STORE = 4'h4,
        OP_HALT  = 4'hf
    } opcode_e;

    typedef struct packed {
        opcode_e               opcode;
        logic [17:0]           unused;
        logic [addr_width-1:0] operand;
    } instr_t;

    // request side of the req/gnt/rvalid handshake
    typedef struct packed {
        logic                  req;
        logic                  we;
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] wdata;
    } mem_req_t;

    // response side where rvalid follows gnt by one cycle
    typedef struct packed {
        logic                  gnt;
        logic                  rvalid;
        logic [data_width-1:0] rdata;
    } mem_rsp_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_EXEC,
        ST_HALT
    } core_state_e;

endpackage

// ==== hdl/mini_core.sv ====
/*
 * mini core
 * accumulator engine with separate instruction and data ports.
 * the next instruction word is prefetched into a one-entry buffer
 * while the data access of the current instruction is in flight
 */
module mini_core (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  fetch_enable_i,
    output mini_ss_pkg::mem_req_t instr_req_o,
    input  mini_ss_pkg::mem_rsp_t instr_rsp_i,
    output mini_ss_pkg::mem_req_t data_req_o,
    input  mini_ss_pkg::mem_rsp_t data_rsp_i,
    output logic                  halted_o
);

    mini_ss_pkg::core_state_e           state_q;
    logic [mini_ss_pkg::addr_width-1:0] pc_q;
    logic [mini_ss_pkg::data_width-1:0] acc_q;

    // prefetch buffer and fetch bookkeeping
    logic [mini_ss_pkg::data_width-1:0] pf_data_q;
    logic                               pf_valid_q;
    logic                               if_pending_q;

    // instruction under execution
    mini_ss_pkg::instr_t                cur_q;
    mini_ss_pkg::instr_t                pf_instr;
    logic                               d_issued_q;

    logic                               running;
    logic                               fetch_start;
    logic                               take_instr;

    assign running = (state_q == mini_ss_pkg::ST_FETCH) || (state_q == mini_ss_pkg::ST_EXEC);

    // fetch whenever the port is idle and the buffer has room.
    // an ungranted request stays up since nothing below can clear it before gnt
    assign fetch_start = running && !if_pending_q && !pf_valid_q;
    assign take_instr  = (state_q == mini_ss_pkg::ST_FETCH) && pf_valid_q;
    assign pf_instr    = mini_ss_pkg::instr_t'(pf_data_q);

    assign instr_req_o.req   = fetch_start;
    assign instr_req_o.we    = 1'b0;
    assign instr_req_o.addr  = pc_q;
    assign instr_req_o.wdata = '0;

    // one data access per operand instruction
    assign data_req_o.req   = (state_q == mini_ss_pkg::ST_EXEC) && !d_issued_q;
    assign data_req_o.we    = (cur_q.opcode == mini_ss_pkg::OP_STORE);
    assign data_req_o.addr  = cur_q.operand;
    assign data_req_o.wdata = acc_q;

    assign halted_o = (state_q == mini_ss_pkg::ST_HALT);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q      <= mini_ss_pkg::ST_IDLE;
            pc_q         <= mini_ss_pkg::boot_addr;
            acc_q        <= '0;
            pf_valid_q   <= 1'b0;
            if_pending_q <= 1'b0;
            d_issued_q   <= 1'b0;
        end else begin
            // gnt and rvalid of the fetch port never meet in one cycle
            if (instr_req_o.req && instr_rsp_i.gnt) begin
                if_pending_q <= 1'b1;
                pc_q         <= pc_q + 1'b1;
            end else if (instr_rsp_i.rvalid) begin
                if_pending_q <= 1'b0;
                pf_valid_q   <= 1'b1;
            end

            case (state_q)
                mini_ss_pkg::ST_IDLE: begin
                    if (fetch_enable_i) begin
                        pc_q    <= mini_ss_pkg::boot_addr;
                        state_q <= mini_ss_pkg::ST_FETCH;
                    end
                end
                mini_ss_pkg::ST_FETCH: begin
                    if (take_instr) begin
                        pf_valid_q <= 1'b0;
                        d_issued_q <= 1'b0;
                        case (pf_instr.opcode)
                            mini_ss_pkg::OP_LOAD,
                            mini_ss_pkg::OP_ADD,
                            mini_ss_pkg::OP_XOR,
                            mini_ss_pkg::OP_STORE: state_q <= mini_ss_pkg::ST_EXEC;
                            default:               state_q <= mini_ss_pkg::ST_HALT;
                        endcase
                    end
                end
                mini_ss_pkg::ST_EXEC: begin
                    if (data_req_o.req && data_rsp_i.gnt) begin
                        d_issued_q <= 1'b1;
                    end
                    if (data_rsp_i.rvalid) begin
                        state_q <= mini_ss_pkg::ST_FETCH;
                        case (cur_q.opcode)
                            mini_ss_pkg::OP_LOAD: acc_q <= data_rsp_i.rdata;
                            mini_ss_pkg::OP_ADD:  acc_q <= acc_q + data_rsp_i.rdata;
                            mini_ss_pkg::OP_XOR:  acc_q <= acc_q ^ data_rsp_i.rdata;
                            default:              acc_q <= acc_q;
                        endcase
                    end
                end
                default: begin
                    // halted until the next reset
                    state_q <= mini_ss_pkg::ST_HALT;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (instr_rsp_i.rvalid) begin
            pf_data_q <= instr_rsp_i.rdata;
        end
        if (take_instr) begin
            cur_q <= pf_instr;
        end
    end

    // core is silent on both ports until fetch is enabled
    a_idle_quiet: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        state_q == mini_ss_pkg::ST_IDLE |-> !data_req_o.req && !instr_req_o.req);

    // a fetch waiting for the arbiter keeps its address
    a_instr_req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        instr_req_o.req && !instr_rsp_i.gnt |=> instr_req_o.req && $stable(instr_req_o.addr));

endmodule

// ==== hdl/mem_arbiter.sv ====
/*
 * memory arbiter
 * fixed priority of core data, core instruction and external port onto
 * one memory port. the granted index is kept for one cycle so the read
 * response goes back to its owner only
 */
module mem_arbiter (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  mini_ss_pkg::mem_req_t data_req_i,
    output mini_ss_pkg::mem_rsp_t data_rsp_o,
    input  mini_ss_pkg::mem_req_t instr_req_i,
    output mini_ss_pkg::mem_rsp_t instr_rsp_o,
    input  mini_ss_pkg::mem_req_t ext_req_i,
    output mini_ss_pkg::mem_rsp_t ext_rsp_o,
    output mini_ss_pkg::mem_req_t mem_req_o,
    input  mini_ss_pkg::mem_rsp_t mem_rsp_i
);

    // requester index is 0 for data, 1 for instr, 2 for ext and 3 for nobody
    logic [1:0] sel;
    logic [1:0] owner_q;

    function automatic mini_ss_pkg::mem_rsp_t route(
        input logic [1:0]            idx,
        input logic [1:0]            cur_sel,
        input logic [1:0]            owner,
        input mini_ss_pkg::mem_rsp_t rsp
    );
        mini_ss_pkg::mem_rsp_t res;
        res.gnt    = rsp.gnt && (cur_sel == idx);
        res.rvalid = rsp.rvalid && (owner == idx);
        res.rdata  = (owner == idx) ? rsp.rdata : '0;
        return res;
    endfunction

    always_comb begin
        if (data_req_i.req) begin
            sel       = 2'd0;
            mem_req_o = data_req_i;
        end else if (instr_req_i.req) begin
            sel       = 2'd1;
            mem_req_o = instr_req_i;
        end else if (ext_req_i.req) begin
            sel       = 2'd2;
            mem_req_o = ext_req_i;
        end else begin
            sel       = 2'd3;
            mem_req_o = '0;
        end
    end

    assign data_rsp_o  = route(2'd0, sel, owner_q, mem_rsp_i);
    assign instr_rsp_o = route(2'd1, sel, owner_q, mem_rsp_i);
    assign ext_rsp_o   = route(2'd2, sel, owner_q, mem_rsp_i);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            owner_q <= 2'd3;
        end else if (mem_req_o.req && mem_rsp_i.gnt) begin
            owner_q <= sel;
        end else begin
            owner_q <= 2'd3;
        end
    end

    a_one_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $onehot0({data_rsp_o.gnt, instr_rsp_o.gnt, ext_rsp_o.gnt}));

    // memory answers every granted access in the next cycle
    a_rvalid_follows: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        mem_req_o.req && mem_rsp_i.gnt |=> mem_rsp_i.rvalid);

endmodule

// ==== hdl/mm_ram.sv ====
/*
 * memory mapped RAM
 * single-port word RAM that grants every request at once and returns
 * read data one cycle later. a write to the exit word is caught by a
 * status register and reports the end of the run with pass/fail
 */
module mm_ram (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    input  mini_ss_pkg::mem_req_t              req_i,
    output mini_ss_pkg::mem_rsp_t              rsp_o,
    output logic                               exit_valid_o,
    output logic                               tests_passed_o,
    output logic                               tests_failed_o,
    output logic [mini_ss_pkg::data_width-1:0] exit_value_o
);

    logic [mini_ss_pkg::data_width-1:0] mem_q [2**mini_ss_pkg::addr_width];

    logic [mini_ss_pkg::data_width-1:0] rdata_q;
    logic                               rvalid_q;

    logic                               exit_valid_q;
    logic                               passed_q;
    logic                               failed_q;
    logic [mini_ss_pkg::data_width-1:0] exit_value_q;

    logic                               exit_sel;
    logic                               exit_hit;

    assign exit_sel = (req_i.addr == mini_ss_pkg::exit_addr);
    assign exit_hit = req_i.req && req_i.we && exit_sel;

    // no wait states
    assign rsp_o.gnt    = req_i.req;
    assign rsp_o.rvalid = rvalid_q;
    assign rsp_o.rdata  = rdata_q;

    assign exit_valid_o   = exit_valid_q;
    assign tests_passed_o = passed_q;
    assign tests_failed_o = failed_q;
    assign exit_value_o   = exit_value_q;

    // the exit word never reaches the array
    always_ff @(posedge clk_i) begin
        if (req_i.req) begin
            if (req_i.we && !exit_sel) begin
                mem_q[req_i.addr] <= req_i.wdata;
            end
            if (exit_sel) begin
                rdata_q <= exit_value_q;
            end else begin
                rdata_q <= mem_q[req_i.addr];
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rvalid_q     <= 1'b0;
            exit_valid_q <= 1'b0;
            passed_q     <= 1'b0;
            failed_q     <= 1'b0;
            exit_value_q <= '0;
        end else begin
            rvalid_q <= req_i.req;
            // only the first exit write is kept
            if (exit_hit && !exit_valid_q) begin
                exit_valid_q <= 1'b1;
                exit_value_q <= req_i.wdata;
                passed_q     <= (req_i.wdata == '0);
                failed_q     <= (req_i.wdata != '0);
            end
        end
    end

    a_pass_xor_fail: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(tests_passed_o && tests_failed_o));

endmodule

// ==== hdl/mini_subsystem.sv ====
/*
 * mini subsystem top
 * accumulator core and external port sharing one memory with
 * exit/status pseudo peripheral through a fixed-priority arbiter
 */
module mini_subsystem (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    input  logic                               fetch_enable_i,
    input  mini_ss_pkg::mem_req_t              ext_req_i,
    output mini_ss_pkg::mem_rsp_t              ext_rsp_o,
    output logic                               halted_o,
    output logic                               exit_valid_o,
    output logic                               tests_passed_o,
    output logic                               tests_failed_o,
    output logic [mini_ss_pkg::data_width-1:0] exit_value_o
);

    // core to arbiter
    mini_ss_pkg::mem_req_t instr_req;
    mini_ss_pkg::mem_rsp_t instr_rsp;
    mini_ss_pkg::mem_req_t data_req;
    mini_ss_pkg::mem_rsp_t data_rsp;

    // arbiter to memory
    mini_ss_pkg::mem_req_t ram_req;
    mini_ss_pkg::mem_rsp_t ram_rsp;

    mini_core core_i (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .fetch_enable_i (fetch_enable_i),
        .instr_req_o    (instr_req),
        .instr_rsp_i    (instr_rsp),
        .data_req_o     (data_req),
        .data_rsp_i     (data_rsp),
        .halted_o       (halted_o)
    );

    mem_arbiter arb_i (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .data_req_i  (data_req),
        .data_rsp_o  (data_rsp),
        .instr_req_i (instr_req),
        .instr_rsp_o (instr_rsp),
        .ext_req_i   (ext_req_i),
        .ext_rsp_o   (ext_rsp_o),
        .mem_req_o   (ram_req),
        .mem_rsp_i   (ram_rsp)
    );

    mm_ram ram_i (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .req_i          (ram_req),
        .rsp_o          (ram_rsp),
        .exit_valid_o   (exit_valid_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_value_o   (exit_value_o)
    );

endmodule

// ==== dv/tb_clk_gen.sv ====
/*
 * testbench clock and reset
 * free running clock of period 40, reset held low for two cycles
 */
module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int half_period = 20;

    initial begin
        clk_o = 1'b0;
        forever #half_period clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// ==== dv/tb_checker.sv ====
/*
 * testbench checker
 * builds a memory image from external port writes, runs the reference
 * accumulator model when fetch is enabled, then checks the exit status,
 * the external port responses and the quiet state after reset
 */
module tb_checker (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  fetch_enable_i,
    input  mini_ss_pkg::mem_req_t ext_req_i,
    input  mini_ss_pkg::mem_rsp_t ext_rsp_i,
    input  logic                  halted_i,
    input  logic                  exit_valid_i,
    input  logic                  tests_passed_i,
    input  logic                  tests_failed_i,
    input  logic [31:0]           exit_value_i,
    output int                    value_errors_o,
    output int                    other_errors_o
);

    logic [31:0] model_mem [1024];
    logic [31:0] exp_value;
    logic        exp_valid;
    logic        quiet;
    logic        exit_seen;
    logic        halt_seen;

    // external access granted in the previous cycle
    logic        pending;
    logic        pend_we;
    logic [9:0]  pend_addr;
    logic [31:0] pend_exp;

    initial begin
        value_errors_o = 0;
        other_errors_o = 0;
    end

    task automatic report_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        value_errors_o++;
        $display("Error %s at %0t: expected %h, actual %h", name, $time, exp, act);
    endtask

    task automatic report_other(input string msg);
        other_errors_o++;
        $display("failure at %0t: %s", $time, msg);
    endtask

    function automatic string region_name(input logic [9:0] addr);
        if (addr >= 10'd512 && addr < 10'd544) begin
            return "readback";
        end
        return "ext_port";
    endfunction

    // executes the preloaded program on the model image in one go
    task automatic run_model();
        mini_ss_pkg::instr_t ins;
        logic [9:0]          pc;
        logic [31:0]         acc;
        logic                done;
        pc        = mini_ss_pkg::boot_addr;
        acc       = '0;
        done      = 1'b0;
        exp_valid = 1'b0;
        while (!done) begin
            ins = mini_ss_pkg::instr_t'(model_mem[pc]);
            pc  = pc + 1'b1;
            case (ins.opcode)
                mini_ss_pkg::OP_LOAD: acc = model_mem[ins.operand];
                mini_ss_pkg::OP_ADD:  acc = acc + model_mem[ins.operand];
                mini_ss_pkg::OP_XOR:  acc = acc ^ model_mem[ins.operand];
                mini_ss_pkg::OP_STORE: begin
                    if (ins.operand != mini_ss_pkg::exit_addr) begin
                        model_mem[ins.operand] = acc;
                    end else if (!exp_valid) begin
                        exp_valid = 1'b1;
                        exp_value = acc;
                    end
                end
                default: done = 1'b1;
            endcase
            if (pc == mini_ss_pkg::boot_addr) begin
                done = 1'b1;
            end
        end
    endtask

    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            quiet     = 1'b1;
            exit_seen = 1'b0;
            halt_seen = 1'b0;
            exp_valid = 1'b0;
            pending   = 1'b0;
        end else begin
            if (quiet && (exit_valid_i || tests_passed_i || tests_failed_i || halted_i)) begin
                report_other("status output went high before fetch_enable_i rose");
            end
            if (fetch_enable_i && quiet) begin
                quiet = 1'b0;
                run_model();
            end

            if (exit_valid_i && !exit_seen) begin
                exit_seen = 1'b1;
                if (!exp_valid) begin
                    report_other("exit word written but the model program never stores to it");
                end else begin
                    if (exit_value_i !== exp_value) begin
                        report_value("exit_value", exp_value, exit_value_i);
                    end
                    if (tests_passed_i !== (exp_value == 32'h0)) begin
                        report_value("tests_passed", exp_value == 32'h0, tests_passed_i);
                    end
                    if (tests_failed_i !== (exp_value != 32'h0)) begin
                        report_value("tests_failed", exp_value != 32'h0, tests_failed_i);
                    end
                end
            end
            if (halted_i && !halt_seen) begin
                halt_seen = 1'b1;
                if (!exit_valid_i) begin
                    report_other("core halted without writing the exit word");
                end
            end

            // external port rvalid comes exactly one cycle after each grant
            if (pending) begin
                if (!ext_rsp_i.rvalid) begin
                    report_other("external port got no rvalid one cycle after its grant");
                end else if (!pend_we && ext_rsp_i.rdata !== pend_exp) begin
                    report_value(region_name(pend_addr), pend_exp, ext_rsp_i.rdata);
                end
            end else if (ext_rsp_i.rvalid) begin
                report_other("external port got rvalid without a grant");
            end
            pending = ext_req_i.req && ext_rsp_i.gnt;
            if (pending) begin
                pend_we   = ext_req_i.we;
                pend_addr = ext_req_i.addr;
                if (ext_req_i.we) begin
                    model_mem[ext_req_i.addr] = ext_req_i.wdata;
                end
                pend_exp = model_mem[ext_req_i.addr];
            end
        end
    end

endmodule

// ==== dv/tb_mini_subsystem.sv ====
/*
 * testbench top for the mini subsystem
 * generates random accumulator programs, preloads them through the
 * external port, runs the core with external traffic alongside and
 * reads the operand window back for the checker
 */
module tb_mini_subsystem;

    localparam int n_programs     = 5;
    localparam int prog_len       = 24;
    localparam int data_base      = 512;
    localparam int data_words     = 32;
    localparam int scratch_base   = 800;
    localparam int zero_program   = 2;
    // budget per program covers preload, 40 instructions at 6 cycles and readback
    localparam int timeout_cycles = n_programs * (60 + 40 * 6 + 40) * 2;

    logic                  clk;
    logic                  gen_rst_n;
    logic                  tb_rst_n;
    logic                  arst_n;
    logic                  fetch_enable;
    mini_ss_pkg::mem_req_t ext_req;
    mini_ss_pkg::mem_rsp_t ext_rsp;
    logic                  halted;
    logic                  exit_valid;
    logic                  tests_passed;
    logic                  tests_failed;
    logic [31:0]           exit_value;
    int                    value_errors;
    int                    other_errors;
    int                    seed;
    int                    cycles;
    logic [31:0]           prog [prog_len + 2];

    assign arst_n = gen_rst_n && tb_rst_n;

    tb_clk_gen clk_gen_i (
        .clk_o   (clk),
        .rst_n_o (gen_rst_n)
    );

    mini_subsystem DUT (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .fetch_enable_i (fetch_enable),
        .ext_req_i      (ext_req),
        .ext_rsp_o      (ext_rsp),
        .halted_o       (halted),
        .exit_valid_o   (exit_valid),
        .tests_passed_o (tests_passed),
        .tests_failed_o (tests_failed),
        .exit_value_o   (exit_value)
    );

    tb_checker checker_i (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .fetch_enable_i (fetch_enable),
        .ext_req_i      (ext_req),
        .ext_rsp_i      (ext_rsp),
        .halted_i       (halted),
        .exit_valid_i   (exit_valid),
        .tests_passed_i (tests_passed),
        .tests_failed_i (tests_failed),
        .exit_value_i   (exit_value),
        .value_errors_o (value_errors),
        .other_errors_o (other_errors)
    );

    function automatic logic [31:0] encode(input mini_ss_pkg::opcode_e op, input int addr);
        mini_ss_pkg::instr_t ins;
        ins.opcode  = op;
        ins.unused  = '0;
        ins.operand = addr[9:0];
        return ins;
    endfunction

    // one access holds req until granted and then waits for rvalid
    task automatic ext_access(input logic we, input int addr, input logic [31:0] wdata);
        @(negedge clk);
        ext_req.req   = 1'b1;
        ext_req.we    = we;
        ext_req.addr  = addr[9:0];
        ext_req.wdata = wdata;
        @(posedge clk);
        while (!ext_rsp.gnt) @(posedge clk);
        @(negedge clk);
        ext_req = '0;
        @(posedge clk);
        while (!ext_rsp.rvalid) @(posedge clk);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        tb_rst_n     = 1'b0;
        fetch_enable = 1'b0;
        ext_req      = '0;
        repeat (2) @(negedge clk);
        tb_rst_n = 1'b1;
    endtask

    task automatic make_program(input int p);
        int op_sel;
        int a;
        for (int i = 0; i < prog_len; i++) begin
            op_sel = {$random(seed)} % 4;
            a      = data_base + {$random(seed)} % data_words;
            case (op_sel)
                0:       prog[i] = encode(mini_ss_pkg::OP_LOAD, a);
                1:       prog[i] = encode(mini_ss_pkg::OP_ADD, a);
                2:       prog[i] = encode(mini_ss_pkg::OP_XOR, a);
                default: prog[i] = encode(mini_ss_pkg::OP_STORE, a);
            endcase
        end
        // a word xored with itself leaves zero in the accumulator
        if (p == zero_program) begin
            a                = data_base + {$random(seed)} % data_words;
            prog[prog_len-2] = encode(mini_ss_pkg::OP_LOAD, a);
            prog[prog_len-1] = encode(mini_ss_pkg::OP_XOR, a);
        end
        prog[prog_len]   = encode(mini_ss_pkg::OP_STORE, mini_ss_pkg::exit_addr);
        prog[prog_len+1] = encode(mini_ss_pkg::OP_HALT, 0);
    endtask

    task automatic preload();
        for (int i = 0; i < prog_len + 2; i++) begin
            ext_access(1'b1, i, prog[i]);
        end
        for (int i = 0; i < data_words; i++) begin
            ext_access(1'b1, data_base + i, $random(seed));
        end
    endtask

    task automatic run_program(input int p);
        int addr;
        @(negedge clk);
        fetch_enable = 1'b1;
        // external traffic competes with the running core
        for (int k = 0; k < 4; k++) begin
            addr = scratch_base + p * 4 + k;
            ext_access(1'b1, addr, $random(seed));
            ext_access(1'b0, addr, '0);
        end
        while (!halted) @(posedge clk);
        @(negedge clk);
        fetch_enable = 1'b0;
    endtask

    task automatic readback();
        for (int i = 0; i < data_words; i++) begin
            ext_access(1'b0, data_base + i, '0);
        end
    endtask

    initial begin
        seed         = 91835;
        tb_rst_n     = 1'b1;
        fetch_enable = 1'b0;
        ext_req      = '0;
        @(posedge gen_rst_n);
        ext_access(1'b1, 700, $random(seed));
        ext_access(1'b0, 700, '0);
        for (int p = 0; p < n_programs; p++) begin
            apply_reset();
            make_program(p);
            preload();
            run_program(p);
            readback();
        end
        @(negedge clk);
        $display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== vlog.f ====
hdl/mini_ss_pkg.sv
hdl/mini_core.sv
hdl/mem_arbiter.sv
hdl/mm_ram.sv
hdl/mini_subsystem.sv
dv/tb_clk_gen.sv
dv/tb_checker.sv
dv/tb_mini_subsystem.sv

// ==== Bender.yml ====
package:
  name: mini_subsystem

sources:
  - files:
      - hdl/mini_ss_pkg.sv
      - hdl/mini_core.sv
      - hdl/mem_arbiter.sv
      - hdl/mm_ram.sv
      - hdl/mini_subsystem.sv

  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_checker.sv
      - dv/tb_mini_subsystem.sv
